//--- sources.f
daq_pkg.sv
pulse_lane.sv
event_readout.sv
pulse_sampler.sv
sampler_checker.sv
sampler_monitor.sv
tb_pulse_sampler.sv

//--- Makefile
# Verilator build and run for the pulse sampler testbench

VERILATOR ?= verilator
TOP       ?= tb_pulse_sampler
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert -Wall
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_pulse_sampler.sv
module tb_pulse_sampler
    import daq_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          N_CH           = DEFAULT_N_CH;
    localparam int          WINDOW         = DEFAULT_WINDOW;
    localparam int          TIMEOUT_CYCLES = 2000;          // About 1300 cycles of tests
    localparam logic [31:0] LFSR_SEED      = 32'h8652a01b;
    localparam logic [31:0] LFSR_TAPS      = 32'h80200003;  // x^32+x^22+x^2+x+1

    typedef logic [N_CH-1:0][WINDOW-1:0] event_t;

    logic        clk = 1'b0;
    logic        rst;
    logic [N_CH-1:0] ch_n;
    logic        trig_thresh;
    logic        event_saved;
    event_t      evento;
    event_t      captured;                          // Event seen by the last trigger
    logic [31:0] lfsr_state      = LFSR_SEED;
    int          cycle_count     = 0;
    int          directed_errors = 0;
    int          mon_errors;
    int          mon_checks;

    always #2 clk = ~clk;                           // 4 ns period

    pulse_sampler #(
        .N_CH   (N_CH),
        .WINDOW (WINDOW)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .ch_n        (ch_n),
        .trig_thresh (trig_thresh),
        .event_saved (event_saved),
        .evento      (evento)
    );

    sampler_monitor #(
        .N_CH   (N_CH),
        .WINDOW (WINDOW)
    ) mon0 (
        .clk         (clk),
        .rst         (rst),
        .ch_n        (ch_n),
        .trig_thresh (trig_thresh),
        .event_saved (event_saved),
        .evento      (evento),
        .error_count (mon_errors),
        .check_count (mon_checks)
    );

    // FSM assertions ride along inside the readout
    bind event_readout sampler_checker #(
        .N_CH   (N_CH),
        .WINDOW (WINDOW)
    ) checker0 (
        .clk         (clk),
        .rst         (rst),
        .read_state  (read_state),
        .event_saved (event_saved),
        .evento      (evento)
    );

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // Galois step shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    task automatic take_bit(output logic b);
        b          = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);         // One step per bit
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #0.5;                                       // Drive just after the edge
    endtask

    // Each channel low with chance 1/4 per cycle
    task automatic random_pulses(input int cycles);
        logic b0;
        logic b1;
        repeat (cycles) begin
            next_cycle();
            for (int c = 0; c < N_CH; c++) begin
                take_bit(b0);
                take_bit(b1);
                ch_n[c] = ~(b0 & b1);
            end
        end
        next_cycle();
        ch_n = '1;
    endtask

    // Trigger seen at the next edge and event two edges later
    task automatic fire_trigger(output event_t ev);
        trig_thresh = 1'b1;
        next_cycle();
        trig_thresh = 1'b0;
        @(posedge clk);
        @(negedge clk);
        ev = evento;
    endtask

    task automatic release_event();
        next_cycle();
        event_saved = 1'b1;                         // One cycle of release
        next_cycle();
        event_saved = 1'b0;
    endtask

    task automatic pulse_once(input int ch);
        next_cycle();
        ch_n[ch] = 1'b0;
        next_cycle();
        ch_n[ch] = 1'b1;
    endtask

    // Only one bit set in the given channel
    task automatic check_single(input event_t ev, input int ch, input int bit_pos);
        logic [WINDOW-1:0] expected;
        expected          = '0;
        expected[bit_pos] = 1'b1;
        if (ev[ch] !== expected) begin
            directed_errors++;
            $display("FAIL t=%0t evento[%0d] got %h expected %h",
                     $time, ch, ev[ch], expected);
        end
    endtask

    task automatic check_empty(input event_t ev);
        if (ev !== '0) begin
            directed_errors++;
            $display("FAIL t=%0t evento got %h expected 0", $time, ev);
        end
    endtask

    //////////////////////////////////////////////////
    // Run limit
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int assert_errors;
        rst         = 1'b1;
        ch_n        = '1;
        ch_n[3]     = 1'b0;                         // Held low across reset release
        trig_thresh = 1'b0;
        event_saved = 1'b0;
        repeat (10) next_cycle();
        rst = 1'b0;

        // Edge on channel 3 still in the sync stages
        fire_trigger(captured);
        check_empty(captured);
        release_event();
        ch_n[3] = 1'b1;

        // Pulse at edge k and trigger at k+21 give bit WINDOW-20
        pulse_once(5);
        repeat (20) next_cycle();
        fire_trigger(captured);
        check_single(captured, 5, WINDOW - 20);
        release_event();

        repeat (4) begin
            random_pulses(4 * WINDOW);
            fire_trigger(captured);
            release_event();
        end

        repeat (WINDOW) next_cycle();               // Flush random bits

        // Long low level gives one edge only
        next_cycle();
        ch_n[9] = 1'b0;
        repeat (30) next_cycle();
        fire_trigger(captured);
        check_single(captured, 9, WINDOW - 29);
        release_event();
        ch_n[9] = 1'b1;

        // Triggers lost while event_saved stays low
        fire_trigger(captured);
        repeat (3) begin
            repeat (5) next_cycle();
            fire_trigger(captured);
            check_empty(captured);
        end
        release_event();
        pulse_once(2);
        repeat (10) next_cycle();
        fire_trigger(captured);
        check_single(captured, 2, WINDOW - 10);
        release_event();
        repeat (4) next_cycle();

        assert_errors = dut0.readout0.checker0.assert_errors;
        $display("Errors: %0d monitor, %0d directed, %0d assertion, over %0d compares",
                 mon_errors, directed_errors, assert_errors, mon_checks);
        if (mon_errors == 0 && directed_errors == 0 && assert_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- sampler_monitor.sv
module sampler_monitor
    import daq_pkg::*;
#(
    parameter int N_CH   = DEFAULT_N_CH,
    parameter int WINDOW = DEFAULT_WINDOW
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [N_CH-1:0]             ch_n,
    input  logic                        trig_thresh,
    input  logic                        event_saved,
    input  logic [N_CH-1:0][WINDOW-1:0] evento,
    output int                          error_count,
    output int                          check_count
);
    timeunit 1ns;
    timeprecision 100ps;

    // Expected sampler state after an edge
    typedef struct packed {
        logic [N_CH-1:0]             sync_meta;
        logic [N_CH-1:0]             sync_q;
        logic [N_CH-1:0]             prev_q;
        logic [N_CH-1:0][WINDOW-1:0] win;
        readout_state_e              state;
        logic [N_CH-1:0][WINDOW-1:0] ev;
    } model_t;

    model_t model;
    logic   model_valid = 1'b0;                     // Set once reset was seen
    int     errors      = 0;
    int     checks      = 0;

    assign error_count = errors;
    assign check_count = checks;

    //////////////////////////////////////////////////
    // Reference model, one edge per call
    //////////////////////////////////////////////////

    function automatic model_t ref_step(input model_t cur, input logic rst_in,
                                        input logic [N_CH-1:0] pins,
                                        input logic trig, input logic saved);
        model_t          nxt;
        logic [N_CH-1:0] rise;
        nxt = '0;
        if (!rst_in) begin
            rise          = cur.sync_q & ~cur.prev_q;   // Edge of the inverted level
            nxt.sync_meta = ~pins;
            nxt.sync_q    = cur.sync_meta;
            nxt.prev_q    = cur.sync_q;
            for (int c = 0; c < N_CH; c++) begin
                nxt.win[c] = {rise[c], cur.win[c][WINDOW-1:1]};
            end
            nxt.ev = (cur.state == READING) ? cur.win : '0;   // Windows before this edge
            case (cur.state)
                STAND_BY: nxt.state = trig ? READING : STAND_BY;
                READING:  nxt.state = WAITING;
                WAITING:  nxt.state = saved ? STAND_BY : WAITING;
                default:  nxt.state = STAND_BY;
            endcase
        end
        return nxt;
    endfunction

    always @(posedge clk) begin
        model <= ref_step(model, rst, ch_n, trig_thresh, event_saved);
        if (rst) begin
            model_valid <= 1'b1;
        end
    end

    // Outputs settled by the falling edge
    always @(negedge clk) begin
        if (model_valid) begin
            for (int c = 0; c < N_CH; c++) begin
                checks++;
                if (evento[c] !== model.ev[c]) begin
                    errors++;
                    $display("FAIL t=%0t evento[%0d] got %h expected %h",
                             $time, c, evento[c], model.ev[c]);
                end
            end
        end
    end

endmodule

//--- sampler_checker.sv
module sampler_checker
    import daq_pkg::*;
#(
    parameter int N_CH   = DEFAULT_N_CH,
    parameter int WINDOW = DEFAULT_WINDOW
) (
    input logic                        clk,
    input logic                        rst,
    input readout_state_e              read_state,
    input logic                        event_saved,
    input logic [N_CH-1:0][WINDOW-1:0] evento
);
    timeunit 1ns;
    timeprecision 100ps;

    int assert_errors = 0;                          // Read by the testbench top

    // READING is a single cycle
    read_one_cycle: assert property (@(posedge clk) disable iff (rst)
        read_state == READING |=> read_state != READING)
        else begin
            assert_errors++;
            $error("READING state lasted two cycles");
        end

    // Event only right after READING
    event_after_read: assert property (@(posedge clk) disable iff (rst)
        evento != '0 |-> $past(read_state) == READING)
        else begin
            assert_errors++;
            $error("evento nonzero outside the cycle after READING");
        end

    wait_release: assert property (@(posedge clk) disable iff (rst)
        (read_state == WAITING && event_saved) |=> read_state == STAND_BY)
        else begin
            assert_errors++;
            $error("WAITING not released by event_saved");
        end

endmodule

//--- pulse_sampler.sv
module pulse_sampler
    import daq_pkg::*;
#(
    parameter int N_CH   = DEFAULT_N_CH,           // Channels sampled
    parameter int WINDOW = DEFAULT_WINDOW          // Window length per channel
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [N_CH-1:0]              ch_n,          // Active low pulses, async
    input  logic                         trig_thresh,   // Trigger level
    input  logic                         event_saved,   // Releases the readout
    output logic [N_CH-1:0][WINDOW-1:0]  evento         // Captured event
);

    // All lane windows side by side
    logic [N_CH-1:0][WINDOW-1:0] windows;

    //////////////////////////////////////////////////
    // Channel lanes
    //////////////////////////////////////////////////

    // One sync, edge detect and shift register per channel
    for (genvar i = 0; i < N_CH; i++) begin : lane_g
        pulse_lane #(
            .WINDOW (WINDOW)
        ) lane (
            .clk     (clk),
            .rst     (rst),
            .pulse_n (ch_n[i]),                    // Pin goes straight in
            .window  (windows[i])
        );
    end

    //////////////////////////////////////////////////
    // Readout
    //////////////////////////////////////////////////

    // Trigger to event latency is two clocks
    event_readout #(
        .N_CH   (N_CH),
        .WINDOW (WINDOW)
    ) readout0 (
        .clk         (clk),
        .rst         (rst),
        .windows     (windows),
        .trig_thresh (trig_thresh),
        .event_saved (event_saved),
        .evento      (evento)
    );

endmodule

//--- event_readout.sv
module event_readout
    import daq_pkg::*;
#(
    parameter int N_CH   = DEFAULT_N_CH,           // Number of lanes
    parameter int WINDOW = DEFAULT_WINDOW          // Samples per lane
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [N_CH-1:0][WINDOW-1:0]  windows,      // Live lane windows
    input  logic                         trig_thresh,  // Trigger level
    input  logic                         event_saved,  // Downstream done, level
    output logic [N_CH-1:0][WINDOW-1:0]  evento        // Snapshot, valid one cycle
);

    // Full event, one window per channel
    typedef logic [N_CH-1:0][WINDOW-1:0] event_t;

    //////////////////////////////////////////////////
    // Readout FSM
    //////////////////////////////////////////////////

    readout_state_e read_state;
    readout_state_e read_state_next;
    logic           load_event;                    // Copy windows on this edge
    event_t         evento_next;

    always_comb begin
        read_state_next = read_state;              // Hold by default
        case (read_state)
            STAND_BY: begin
                // Trigger only looked at here
                if (trig_thresh) begin
                    read_state_next = READING;
                end
            end
            READING: begin
                read_state_next = WAITING;         // Always exactly one cycle
            end
            WAITING: begin
                // Triggers lost until downstream releases us
                if (event_saved) begin
                    read_state_next = STAND_BY;
                end
            end
            default: begin
                read_state_next = STAND_BY;        // Recover from unused code 2'd3
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Event register
    //////////////////////////////////////////////////

    assign load_event = (read_state == READING);

    // Snapshot in READING, zeros otherwise
    always_comb begin
        if (load_event) begin
            evento_next = windows;                 // Windows as they stand this cycle
        end else begin
            evento_next = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_state <= STAND_BY;
            evento     <= '0;
        end else begin
            read_state <= read_state_next;
            evento     <= evento_next;             // Nonzero only the cycle after READING
        end
    end

    // Trigger at edge t  -> READING after t
    // Edge t+1           -> evento loaded, WAITING
    // Edge t+2           -> evento back to zero

endmodule

//--- pulse_lane.sv
module pulse_lane
    import daq_pkg::*;
#(
    parameter int WINDOW = DEFAULT_WINDOW          // Samples kept in the window
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              pulse_n,             // Active low channel input, async
    output logic [WINDOW-1:0] window               // Newest sample at top bit
);

    // One channel window, bit WINDOW-1 is the newest sample
    typedef logic [WINDOW-1:0] window_t;

    //////////////////////////////////////////////////
    // Input stage
    //////////////////////////////////////////////////

    logic    pulse;                                // Active high copy of the input
    logic    sync_meta;                            // First sync stage, may go metastable
    logic    sync_q;                               // Second sync stage, safe to use
    logic    prev_q;                               // sync_q one clock later
    logic    rise;                                 // Rising edge of synced level

    assign pulse = ~pulse_n;

    // Two flop synchronizer plus history flop
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_meta <= 1'b0;
            sync_q    <= 1'b0;
            prev_q    <= 1'b0;
        end else begin
            sync_meta <= pulse;
            sync_q    <= sync_meta;
            prev_q    <= sync_q;
        end
    end

    // High for one cycle per low-going pulse on the pin
    // A long low level gives a single detection
    assign rise = sync_q & ~prev_q;

    //////////////////////////////////////////////////
    // Window shift register
    //////////////////////////////////////////////////

    window_t win_q;
    window_t win_next;

    // Detection enters at the top, everything moves toward bit 0
    always_comb begin
        win_next = {rise, win_q[WINDOW-1:1]};     // Bit 0 falls off the end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            win_q <= '0;                           // Empty window after reset
        end else begin
            win_q <= win_next;                     // Shifts every clock, never stalls
        end
    end

    // Current contents go straight to the readout
    assign window = win_q;

endmodule

//--- daq_pkg.sv
package daq_pkg;

    //////////////////////////////////////////////////
    // Front end defaults
    //////////////////////////////////////////////////

    // Channels per sampler board
    parameter int DEFAULT_N_CH   = 16;

    // Samples held per channel window, one per clock
    parameter int DEFAULT_WINDOW = 64;

    //////////////////////////////////////////////////
    // Readout FSM
    //////////////////////////////////////////////////

    // STAND_BY  waits for trig_thresh
    // READING   one cycle, windows copied to evento
    // WAITING   holds off triggers until event_saved
    typedef enum logic [1:0] {
        STAND_BY = 2'd0,
        READING  = 2'd1,
        WAITING  = 2'd2
    } readout_state_e;

endpackage
